/* files.f */
common/awg_pkg.sv
common/awg_cfg_if.sv
rtl/apb_regs.sv
awg/dma_writer.sv
awg/sample_buffer.sv
awg/awg_sequencer.sv
rtl/awg_top.sv
test/awg_tb.sv

/* run.sh */
#!/bin/sh
# build the AWG testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module awg_tb -f files.f -o awg_sim \
  && ./obj_dir/awg_sim | tee /dev/stderr | grep -qF ">>> PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* test/awg_tb.sv */
// --------------------
// self-checking testbench and top module of the AWG simulation
// drives APB and the sample stream and checks the DAC outputs
// --------------------
`default_nettype none

module awg_tb import awg_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 2000;

  logic                dma_clk;
  logic                rst_i;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [APB_AW-1:0]   paddr;
  logic [APB_DW-1:0]   pwdata;
  logic [APB_DW-1:0]   prdata;
  logic                pready;
  logic                pslverr;
  logic [WORD_W-1:0]   s_tdata;
  logic                s_tvalid;
  logic                s_tlast;
  logic                s_tready;
  logic [WORD_W-1:0]   dac_data;
  logic [CHANNELS-1:0] dac_valid;
  logic [CHANNELS-1:0] dac_trigger;

  string       test_name;
  int          errors = 0;
  int          errors_before = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int unsigned lcg_state = 16;
  int          cyc = 0;
  int          acc_cyc = 0;

  // expected configuration and buffer contents
  int                  cfg_dm1   [CHANNELS];
  int                  cfg_burst [CHANNELS];
  int                  cfg_trig  [CHANNELS];
  logic [SAMPLE_W-1:0] model_mem [CHANNELS][DEPTH];

  // what the DAC side actually produced
  logic [SAMPLE_W-1:0] obs_data  [CHANNELS][$];
  logic                obs_trig  [CHANNELS][$];
  int                  first_cyc [CHANNELS];
  int                  last_cyc  [CHANNELS];

  awg_top uut (
    .dma_clk       (dma_clk),
    .rst_i         (rst_i),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .paddr_i       (paddr),
    .pwdata_i      (pwdata),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .pslverr_o     (pslverr),
    .s_tdata_i     (s_tdata),
    .s_tvalid_i    (s_tvalid),
    .s_tlast_i     (s_tlast),
    .s_tready_o    (s_tready),
    .dac_data_o    (dac_data),
    .dac_valid_o   (dac_valid),
    .dac_trigger_o (dac_trigger)
  );

  initial dma_clk = 1'b0;
  always #2 dma_clk = ~dma_clk;

  always @(posedge dma_clk) begin
    cyc <= cyc + 1;
  end

  // collect valid DAC samples and the cycles they show up in
  always @(negedge dma_clk) begin
    if (!rst_i) begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (dac_valid[c]) begin
          obs_data[c].push_back(dac_data[c*SAMPLE_W +: SAMPLE_W]);
          obs_trig[c].push_back(dac_trigger[c]);
          if (first_cyc[c] < 0) first_cyc[c] = cyc;
          last_cyc[c] = cyc;
        end
      end
    end
  end

  for (genvar c = 0; c < CHANNELS; c++) begin : g_trig_check
    // a trigger only ever rides on a valid sample
    assert property (@(posedge dma_clk) disable iff (rst_i) dac_trigger[c] |-> dac_valid[c])
      else begin
        $display("%s: trigger on channel %0d without a valid sample", test_name, c);
        errors++;
      end
  end

  function automatic int unsigned rand_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic int frame_len();
    int m;
    m = 0;
    for (int c = 0; c < CHANNELS; c++) begin
      if (cfg_dm1[c] > m) m = cfg_dm1[c];
    end
    return m + 1;
  endfunction

  // register value as the field layout of the register map defines it
  function automatic logic [APB_DW-1:0] reg_image(input logic [APB_AW-1:0] addr);
    logic [APB_DW-1:0] r;
    r = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      case (addr)
        REG_DEPTH: r[c*FIELD_STRIDE +: ADDR_W]  = ADDR_W'(cfg_dm1[c]);
        REG_BURST: r[c*FIELD_STRIDE +: BURST_W] = BURST_W'(cfg_burst[c]);
        default:   r[c*FIELD_STRIDE +: 2]       = 2'(cfg_trig[c]);
      endcase
    end
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("%s: %s", test_name, why);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic test_begin(input string name);
    test_name = name;
    errors_before = errors;
  endtask

  task automatic test_end();
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - errors_before);
    end
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                           output logic err);
    @(negedge dma_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge dma_clk);
    penable = 1'b1;
    #1;
    err     = pslverr;
    acc_cyc = cyc;
    @(negedge dma_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                          output logic err);
    @(negedge dma_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge dma_clk);
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    @(negedge dma_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_ok(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    logic err;
    apb_write(addr, data, err);
    check_eq($sformatf("pslverr on write to %0h", addr), 32'd0, 32'(err));
  endtask

  task automatic write_config();
    write_ok(REG_DEPTH, reg_image(REG_DEPTH));
    write_ok(REG_BURST, reg_image(REG_BURST));
    write_ok(REG_TRIG, reg_image(REG_TRIG));
  endtask

  task automatic check_config();
    logic [APB_DW-1:0] rd;
    logic              err;
    apb_read(REG_DEPTH, rd, err);
    check_eq("DEPTH readback", reg_image(REG_DEPTH), rd);
    apb_read(REG_BURST, rd, err);
    check_eq("BURST readback", reg_image(REG_BURST), rd);
    apb_read(REG_TRIG, rd, err);
    check_eq("TRIG readback", reg_image(REG_TRIG), rd);
  endtask

  task automatic check_status(input awg_state_e st, input logic xerr);
    logic [APB_DW-1:0] rd;
    logic              err;
    apb_read(REG_STATUS, rd, err);
    check_eq("STATUS state", 32'(st), 32'(rd[1:0]));
    check_eq("STATUS transfer error", 32'(xerr), 32'(rd[2]));
  endtask

  task automatic wait_state(input awg_state_e st);
    logic [APB_DW-1:0] rd;
    logic              err;
    int                n;
    n = 0;
    apb_read(REG_STATUS, rd, err);
    while (rd[1:0] != st) begin
      n++;
      if (n == TIMEOUT) abort_run($sformatf("state %0d not reached in time", st));
      apb_read(REG_STATUS, rd, err);
    end
  endtask

  // only words inside the frame land in the buffer
  task automatic stream_frame(input int n_words, input int tlast_idx, input bit gaps);
    logic [WORD_W-1:0] word;
    int                n;
    for (int i = 0; i < n_words; i++) begin
      if (gaps && (rand_next() % 3 == 0)) begin
        @(negedge dma_clk);
        s_tvalid = 1'b0;
      end
      for (int c = 0; c < CHANNELS; c++) begin
        word[c*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'(rand_next());
        if (i < frame_len()) model_mem[c][i] = word[c*SAMPLE_W +: SAMPLE_W];
      end
      @(negedge dma_clk);
      s_tdata  = word;
      s_tvalid = 1'b1;
      s_tlast  = (i == tlast_idx);
      n = 0;
      while (!s_tready) begin
        @(negedge dma_clk);
        n++;
        if (n == TIMEOUT) abort_run("stream word was never accepted");
      end
    end
    @(negedge dma_clk);
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
  endtask

  // start playback and compare every channel with the playback rule
  task automatic play_check(input bit poke);
    logic err;
    int   start_cyc;
    int   len;
    int   per;
    bit   exp_t;
    for (int c = 0; c < CHANNELS; c++) begin
      obs_data[c].delete();
      obs_trig[c].delete();
      first_cyc[c] = -1;
      last_cyc[c]  = -1;
    end
    apb_write(REG_CTRL, 32'h2, err);
    start_cyc = acc_cyc;
    check_eq("pslverr on start", 32'd0, 32'(err));
    if (poke) begin
      apb_write(REG_CTRL, 32'h2, err);
      apb_write(REG_BURST, 32'h0000_7777, err);
      check_eq("pslverr on config write while playing", 32'd1, 32'(err));
    end
    wait_state(ST_LOADED);
    for (int c = 0; c < CHANNELS; c++) begin
      per = cfg_dm1[c] + 1;
      len = per * cfg_burst[c];
      check_eq($sformatf("ch%0d valid samples", c), 32'(len), 32'(obs_data[c].size()));
      if (len > 0) begin
        check_eq($sformatf("ch%0d first valid cycle", c), 32'(start_cyc + 3),
                 32'(first_cyc[c]));
        // samples follow back to back, so the last one lands len - 1 cycles later
        check_eq($sformatf("ch%0d last valid cycle", c), 32'(start_cyc + 2 + len),
                 32'(last_cyc[c]));
      end
      for (int k = 0; k < len && k < obs_data[c].size(); k++) begin
        exp_t = (k % per == 0) &&
                ((cfg_trig[c] == TRIG_EVERY) || ((cfg_trig[c] == TRIG_FIRST) && (k < per)));
        check_eq($sformatf("ch%0d sample %0d", c, k), 32'(model_mem[c][k % per]),
                 32'(obs_data[c][k]));
        check_eq($sformatf("ch%0d trigger %0d", c, k), 32'(exp_t), 32'(obs_trig[c][k]));
      end
    end
  endtask

  initial begin
    logic [APB_DW-1:0] rd;
    logic              err;
    int                n;

    rst_i    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    s_tdata  = '0;
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      first_cyc[c] = -1;
      last_cyc[c]  = -1;
    end
    repeat (5) @(posedge dma_clk);
    @(negedge dma_clk);
    rst_i = 1'b0;

    test_begin("registers");
    check_status(ST_IDLE, 1'b0);
    check_eq("pready", 32'd1, 32'(pready));
    check_eq("tready before arm", 32'd0, 32'(s_tready));
    cfg_dm1   = '{42, 17};
    cfg_burst = '{5, 3};
    cfg_trig  = '{1, 2};
    write_config();
    check_config();
    apb_write(5'h14, 32'h1, err);
    check_eq("pslverr on unmapped write", 32'd1, 32'(err));
    apb_read(5'h18, rd, err);
    check_eq("pslverr on unmapped read", 32'd1, 32'(err));
    apb_read(REG_CTRL, rd, err);
    check_eq("pslverr on CTRL read", 32'd1, 32'(err));
    apb_write(REG_STATUS, 32'h3, err);
    check_eq("pslverr on STATUS write", 32'd1, 32'(err));
    check_eq("tready still before arm", 32'd0, 32'(s_tready));
    test_end();

    test_begin("load_play");
    cfg_dm1[0]   = DEPTH - 1;
    cfg_dm1[1]   = int'(rand_next() % (DEPTH - 1));
    cfg_burst    = '{2, 3};
    cfg_trig     = '{int'(TRIG_EVERY), int'(TRIG_FIRST)};
    write_config();
    write_ok(REG_CTRL, 32'h1);
    stream_frame(frame_len(), frame_len() - 1, 1'b1);
    wait_state(ST_LOADED);
    check_status(ST_LOADED, 1'b0);
    play_check(1'b0);
    // a channel with no bursts stays silent
    cfg_burst[1] = 0;
    write_config();
    play_check(1'b0);
    test_end();

    test_begin("triggers");
    cfg_burst = '{3, 3};
    cfg_trig  = '{int'(TRIG_NONE), int'(TRIG_EVERY)};
    write_config();
    play_check(1'b0);
    // code 3 has no name and must stay quiet
    cfg_trig = '{int'(TRIG_FIRST), 3};
    write_config();
    play_check(1'b0);
    test_end();

    test_begin("xfer_errors");
    write_ok(REG_CTRL, 32'h1);
    stream_frame(10, 9, 1'b1);
    wait_state(ST_LOADED);
    check_status(ST_LOADED, 1'b1);
    write_ok(REG_CTRL, 32'h1);
    check_status(ST_LOAD, 1'b0);
    stream_frame(frame_len() + 2, frame_len() + 1, 1'b1);
    wait_state(ST_LOADED);
    check_status(ST_LOADED, 1'b1);
    write_ok(REG_CTRL, 32'h1);
    check_status(ST_LOAD, 1'b0);
    stream_frame(frame_len(), frame_len() - 1, 1'b0);
    wait_state(ST_LOADED);
    check_status(ST_LOADED, 1'b0);
    play_check(1'b0);
    test_end();

    test_begin("start_stop");
    play_check(1'b1);
    check_config();
    check_status(ST_LOADED, 1'b0);
    play_check(1'b0);
    write_ok(REG_CTRL, 32'h2);
    n = 0;
    while (dac_valid == '0) begin
      @(negedge dma_clk);
      n++;
      if (n == TIMEOUT) abort_run("playback never produced a valid sample");
    end
    write_ok(REG_CTRL, 32'h4);
    repeat (2) @(negedge dma_clk);
    check_eq("valids two cycles after stop", 32'd0, 32'(dac_valid));
    check_status(ST_IDLE, 1'b0);
    // start from idle has no effect
    write_ok(REG_CTRL, 32'h2);
    repeat (4) begin
      @(negedge dma_clk);
      check_eq("valids after start in idle", 32'd0, 32'(dac_valid));
    end
    check_status(ST_IDLE, 1'b0);
    test_end();

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/awg_top.sv */
// --------------------
// AWG top level: APB config, stream load, DAC sample outputs
// --------------------
`default_nettype none

module awg_top import awg_pkg::*; (
  input  wire logic                dma_clk,
  input  wire logic                rst_i,
  // APB
  input  wire logic                psel_i,
  input  wire logic                penable_i,
  input  wire logic                pwrite_i,
  input  wire logic [APB_AW-1:0]   paddr_i,
  input  wire logic [APB_DW-1:0]   pwdata_i,
  output logic      [APB_DW-1:0]   prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  // sample stream
  input  wire logic [WORD_W-1:0]   s_tdata_i,
  input  wire logic                s_tvalid_i,
  input  wire logic                s_tlast_i,
  output logic                     s_tready_o,
  // DAC side
  output logic      [WORD_W-1:0]   dac_data_o,
  output logic      [CHANNELS-1:0] dac_valid_o,
  output logic      [CHANNELS-1:0] dac_trigger_o
);

  logic                              wr_en;
  logic [ADDR_W-1:0]                 wr_addr;
  logic [WORD_W-1:0]                 wr_data;
  logic [CHANNELS-1:0][ADDR_W-1:0]   rd_addr;
  logic [CHANNELS-1:0][SAMPLE_W-1:0] rd_data;

  awg_cfg_if cfg ();

  apb_regs u_regs (
    .dma_clk   (dma_clk),
    .rst_i     (rst_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg       (cfg.regs)
  );

  dma_writer u_writer (
    .dma_clk    (dma_clk),
    .rst_i      (rst_i),
    .s_tdata_i  (s_tdata_i),
    .s_tvalid_i (s_tvalid_i),
    .s_tlast_i  (s_tlast_i),
    .s_tready_o (s_tready_o),
    .wr_en_o    (wr_en),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .cfg        (cfg.writer)
  );

  sample_buffer u_buffer (
    .dma_clk   (dma_clk),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  awg_sequencer u_seq (
    .dma_clk       (dma_clk),
    .rst_i         (rst_i),
    .rd_data_i     (rd_data),
    .rd_addr_o     (rd_addr),
    .dac_data_o    (dac_data_o),
    .dac_valid_o   (dac_valid_o),
    .dac_trigger_o (dac_trigger_o),
    .cfg           (cfg.seq)
  );

endmodule

`default_nettype wire

/* awg/awg_sequencer.sv */
// --------------------
// AWG state machine and per-channel playback: walks each waveform
// burst_len times and lines valid and trigger up with buffer data
// --------------------
`default_nettype none

module awg_sequencer import awg_pkg::*; (
  input  wire logic                                 dma_clk,
  input  wire logic                                 rst_i,
  input  wire logic    [CHANNELS-1:0][SAMPLE_W-1:0] rd_data_i,
  output logic         [CHANNELS-1:0][ADDR_W-1:0]   rd_addr_o,
  output logic         [WORD_W-1:0]                 dac_data_o,
  output logic         [CHANNELS-1:0]               dac_valid_o,
  output logic         [CHANNELS-1:0]               dac_trigger_o,
  awg_cfg_if.seq                                    cfg
);

  awg_state_e state_q;

  logic [CHANNELS-1:0][ADDR_W-1:0]  cnt_q;
  logic [CHANNELS-1:0][BURST_W-1:0] pass_q;
  logic [CHANNELS-1:0]              active_q;
  logic [CHANNELS-1:0]              trig_a;
  logic [CHANNELS-1:0]              valid_q;
  logic [CHANNELS-1:0]              trig_q;

  logic arm_ok;
  logic start_ok;

  // arm wins over start when both arrive in ST_LOADED
  assign arm_ok   = cfg.arm && ((state_q == ST_IDLE) || (state_q == ST_LOADED));
  assign start_ok = cfg.start && !cfg.arm && (state_q == ST_LOADED);

  always_ff @(posedge dma_clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else if (cfg.stop) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (arm_ok) state_q <= ST_LOAD;
        end
        ST_LOAD: begin
          if (cfg.load_done) state_q <= ST_LOADED;
        end
        ST_LOADED: begin
          if (arm_ok) begin
            state_q <= ST_LOAD;
          end else if (start_ok) begin
            state_q <= ST_PLAY;
          end
        end
        ST_PLAY: begin
          // last address went out last cycle, its sample shows now
          if (active_q == '0) state_q <= ST_LOADED;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign cfg.state = state_q;

  // address stage: sample and pass counters per channel
  always_ff @(posedge dma_clk) begin
    if (rst_i) begin
      cnt_q    <= '0;
      pass_q   <= '0;
      active_q <= '0;
    end else if (cfg.stop) begin
      active_q <= '0;
    end else if (start_ok) begin
      cnt_q  <= '0;
      pass_q <= '0;
      for (int c = 0; c < CHANNELS; c++) begin
        active_q[c] <= (cfg.burst_len[c] != '0);
      end
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (active_q[c]) begin
          if (cnt_q[c] == cfg.depth_m1[c]) begin
            cnt_q[c] <= '0;
            if (pass_q[c] == cfg.burst_len[c] - 1'b1) begin
              active_q[c] <= 1'b0;
            end else begin
              pass_q[c] <= pass_q[c] + 1'b1;
            end
          end else begin
            cnt_q[c] <= cnt_q[c] + 1'b1;
          end
        end
      end
    end
  end

  // trigger on sample 0, every pass or only the first
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      trig_a[c] = active_q[c] && (cnt_q[c] == '0) &&
                  ((cfg.trig_mode[c] == TRIG_EVERY) ||
                   ((cfg.trig_mode[c] == TRIG_FIRST) && (pass_q[c] == '0)));
    end
  end

  assign rd_addr_o = cnt_q;

  // one stage delay to match the buffer read latency
  always_ff @(posedge dma_clk) begin
    if (rst_i || cfg.stop) begin
      valid_q <= '0;
      trig_q  <= '0;
    end else begin
      valid_q <= active_q;
      trig_q  <= trig_a;
    end
  end

  assign dac_data_o    = rd_data_i;
  assign dac_valid_o   = valid_q;
  assign dac_trigger_o = trig_q;

endmodule

`default_nettype wire

/* awg/sample_buffer.sv */
// --------------------
// one sample memory per channel, shared write port,
// independent registered reads
// --------------------
`default_nettype none

module sample_buffer import awg_pkg::*; (
  input  wire logic                              dma_clk,
  input  wire logic                              wr_en_i,
  input  wire logic [ADDR_W-1:0]                 wr_addr_i,
  input  wire logic [WORD_W-1:0]                 wr_data_i,
  input  wire logic [CHANNELS-1:0][ADDR_W-1:0]   rd_addr_i,
  output logic      [CHANNELS-1:0][SAMPLE_W-1:0] rd_data_o
);

  for (genvar c = 0; c < CHANNELS; c++) begin : g_chan
    logic [SAMPLE_W-1:0] mem [DEPTH];
    logic [SAMPLE_W-1:0] rd_q;

    // each channel stores its own slice of the stream word
    always_ff @(posedge dma_clk) begin
      if (wr_en_i) begin
        mem[wr_addr_i] <= wr_data_i[c*SAMPLE_W +: SAMPLE_W];
      end
    end

    always_ff @(posedge dma_clk) begin
      rd_q <= mem[rd_addr_i[c]];
    end

    assign rd_data_o[c] = rd_q;
  end

endmodule

`default_nettype wire

/* awg/dma_writer.sv */
// --------------------
// takes stream words while loading, writes them to the sample
// buffer and checks that tlast lands on the last word of the frame
// --------------------
`default_nettype none

module dma_writer import awg_pkg::*; (
  input  wire logic              dma_clk,
  input  wire logic              rst_i,
  input  wire logic [WORD_W-1:0] s_tdata_i,
  input  wire logic              s_tvalid_i,
  input  wire logic              s_tlast_i,
  output logic                   s_tready_o,
  output logic                   wr_en_o,
  output logic      [ADDR_W-1:0] wr_addr_o,
  output logic      [WORD_W-1:0] wr_data_o,
  awg_cfg_if.writer              cfg
);

  logic [ADDR_W-1:0] frame_m1;
  logic [ADDR_W-1:0] idx_q;
  logic              drop_q;
  logic              err_q;
  logic              beat;
  logic              arm_ok;

  // frame length follows the deepest channel
  always_comb begin
    frame_m1 = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      if (cfg.depth_m1[c] > frame_m1) begin
        frame_m1 = cfg.depth_m1[c];
      end
    end
  end

  assign s_tready_o = (cfg.state == ST_LOAD);
  assign beat       = s_tvalid_i && s_tready_o;
  assign arm_ok     = cfg.arm && ((cfg.state == ST_IDLE) || (cfg.state == ST_LOADED));

  // words after a missing tlast are swallowed, not written
  assign wr_en_o   = beat && !drop_q;
  assign wr_addr_o = idx_q;
  assign wr_data_o = s_tdata_i;

  // any tlast ends the load, good frame or not
  assign cfg.load_done  = beat && s_tlast_i;
  assign cfg.xfer_error = err_q;

  always_ff @(posedge dma_clk) begin
    if (rst_i) begin
      idx_q  <= '0;
      drop_q <= 1'b0;
      err_q  <= 1'b0;
    end else if (arm_ok) begin
      idx_q  <= '0;
      drop_q <= 1'b0;
      err_q  <= 1'b0;
    end else if (beat) begin
      if (drop_q) begin
        if (s_tlast_i) begin
          drop_q <= 1'b0;
        end
      end else if (s_tlast_i) begin
        // early tlast
        if (idx_q != frame_m1) begin
          err_q <= 1'b1;
        end
      end else if (idx_q == frame_m1) begin
        // last word came without tlast, drop until it shows up
        err_q  <= 1'b1;
        drop_q <= 1'b1;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/apb_regs.sv */
// --------------------
// APB slave holding the AWG configuration; CTRL writes become
// registered command pulses, STATUS reflects the live state
// --------------------
`default_nettype none

module apb_regs import awg_pkg::*; (
  input  wire logic              dma_clk,
  input  wire logic              rst_i,
  input  wire logic              psel_i,
  input  wire logic              penable_i,
  input  wire logic              pwrite_i,
  input  wire logic [APB_AW-1:0] paddr_i,
  input  wire logic [APB_DW-1:0] pwdata_i,
  output logic      [APB_DW-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  awg_cfg_if.regs                cfg
);

  logic [CHANNELS-1:0][ADDR_W-1:0]  depth_q;
  logic [CHANNELS-1:0][BURST_W-1:0] burst_q;
  trig_mode_e [CHANNELS-1:0]        trig_q;

  logic              access;
  logic              busy;
  logic              bad_access;
  logic              cfg_wr;
  logic              ctrl_wr;
  logic [APB_DW-1:0] rd_data;

  logic arm_q;
  logic start_q;
  logic stop_q;

  // no wait states, every access phase completes at once
  assign pready_o = 1'b1;

  assign access  = psel_i && penable_i;
  assign busy    = (cfg.state == ST_LOAD) || (cfg.state == ST_PLAY);
  assign cfg_wr  = access && pwrite_i && !busy;
  assign ctrl_wr = access && pwrite_i && (paddr_i == REG_CTRL);

  // read mux and access checks
  always_comb begin
    rd_data    = '0;
    bad_access = 1'b0;
    case (paddr_i)
      REG_CTRL: begin
        bad_access = !pwrite_i;
      end
      REG_STATUS: begin
        bad_access = pwrite_i;
        rd_data[1:0] = cfg.state;
        rd_data[2]   = cfg.xfer_error;
      end
      REG_DEPTH: begin
        bad_access = pwrite_i && busy;
        for (int c = 0; c < CHANNELS; c++) begin
          rd_data[c*FIELD_STRIDE +: ADDR_W] = depth_q[c];
        end
      end
      REG_BURST: begin
        bad_access = pwrite_i && busy;
        for (int c = 0; c < CHANNELS; c++) begin
          rd_data[c*FIELD_STRIDE +: BURST_W] = burst_q[c];
        end
      end
      REG_TRIG: begin
        bad_access = pwrite_i && busy;
        for (int c = 0; c < CHANNELS; c++) begin
          rd_data[c*FIELD_STRIDE +: 2] = trig_q[c];
        end
      end
      default: begin
        bad_access = 1'b1;
      end
    endcase
  end

  assign prdata_o  = (access && !pwrite_i) ? rd_data : '0;
  assign pslverr_o = access && bad_access;

  // configuration fields, locked while loading or playing
  always_ff @(posedge dma_clk) begin
    if (rst_i) begin
      depth_q <= '0;
      burst_q <= '0;
      trig_q  <= {CHANNELS{TRIG_NONE}};
    end else if (cfg_wr) begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (paddr_i == REG_DEPTH) begin
          depth_q[c] <= pwdata_i[c*FIELD_STRIDE +: ADDR_W];
        end
        if (paddr_i == REG_BURST) begin
          burst_q[c] <= pwdata_i[c*FIELD_STRIDE +: BURST_W];
        end
        if (paddr_i == REG_TRIG) begin
          trig_q[c] <= trig_mode_e'(pwdata_i[c*FIELD_STRIDE +: 2]);
        end
      end
    end
  end

  // stop in the same write masks arm and start
  always_ff @(posedge dma_clk) begin
    if (rst_i) begin
      arm_q   <= 1'b0;
      start_q <= 1'b0;
      stop_q  <= 1'b0;
    end else begin
      arm_q   <= ctrl_wr && pwdata_i[0] && !pwdata_i[2];
      start_q <= ctrl_wr && pwdata_i[1] && !pwdata_i[2];
      stop_q  <= ctrl_wr && pwdata_i[2];
    end
  end

  assign cfg.depth_m1  = depth_q;
  assign cfg.burst_len = burst_q;
  assign cfg.trig_mode = trig_q;
  assign cfg.arm       = arm_q;
  assign cfg.start     = start_q;
  assign cfg.stop      = stop_q;

endmodule

`default_nettype wire

/* common/awg_cfg_if.sv */
// --------------------
// configuration, command pulses and status shared by the
// register block, the stream writer and the sequencer
// --------------------
`default_nettype none

interface awg_cfg_if import awg_pkg::*; ();

  // configuration from the register block
  logic [CHANNELS-1:0][ADDR_W-1:0]  depth_m1;
  logic [CHANNELS-1:0][BURST_W-1:0] burst_len;
  trig_mode_e [CHANNELS-1:0]        trig_mode;

  // one-cycle command pulses
  logic arm;
  logic start;
  logic stop;

  // status
  awg_state_e state;
  logic       load_done;
  logic       xfer_error;

  modport regs (
    output depth_m1, burst_len, trig_mode, arm, start, stop,
    input  state, xfer_error
  );

  modport seq (
    output state,
    input  depth_m1, burst_len, trig_mode, arm, start, stop, load_done, xfer_error
  );

  modport writer (
    output load_done, xfer_error,
    input  depth_m1, state, arm
  );

endinterface

`default_nettype wire

/* common/awg_pkg.sv */
// --------------------
// sizes, APB register map and enums shared by the AWG blocks
// --------------------
`default_nettype none

package awg_pkg;

  // output channels, each with its own waveform
  localparam int CHANNELS = 2;

  // buffer words per channel
  localparam int DEPTH  = 64;
  localparam int ADDR_W = $clog2(DEPTH);

  // one stream word holds a sample for every channel, channel 0 in the low bits
  localparam int SAMPLE_W = 16;
  localparam int WORD_W   = CHANNELS * SAMPLE_W;

  localparam int BURST_W = 8;

  localparam int APB_AW = 5;
  localparam int APB_DW = 32;

  // per-channel fields in DEPTH, BURST and TRIG sit this far apart
  localparam int FIELD_STRIDE = 8;

  localparam logic [APB_AW-1:0] REG_CTRL   = 5'h00;
  localparam logic [APB_AW-1:0] REG_STATUS = 5'h04;
  localparam logic [APB_AW-1:0] REG_DEPTH  = 5'h08;
  localparam logic [APB_AW-1:0] REG_BURST  = 5'h0C;
  localparam logic [APB_AW-1:0] REG_TRIG   = 5'h10;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_LOAD   = 2'd1,
    ST_LOADED = 2'd2,
    ST_PLAY   = 2'd3
  } awg_state_e;

  // code 3 is not named and acts like TRIG_NONE
  typedef enum logic [1:0] {
    TRIG_NONE  = 2'd0,
    TRIG_EVERY = 2'd1,
    TRIG_FIRST = 2'd2
  } trig_mode_e;

endpackage

`default_nettype wire
